// ==== bpsi_macros.svh ====
`ifndef BPSI_MACROS_SVH
`define BPSI_MACROS_SVH

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// raw sensor sample, a and b channels
`define BPSI_SENS_W 24
// signed position, one bit wider than a sample
`define BPSI_POS_W 25
// motor drive and feedback word
`define BPSI_VOL_W 16
// pid coefficient, 6 integer bits + 20 fraction bits
`define BPSI_COEF_W 26
`define BPSI_COEF_FRAC 20

////////////////////////////////////////////////////////////
// motor trigger periods, clock cycles
////////////////////////////////////////////////////////////

// scaled down so simulation stays short
`define BPSI_TRIG_100HZ 300
`define BPSI_TRIG_200HZ 150
`define BPSI_TRIG_300HZ 100

// samples inside threshold before loop reports closed
`define BPSI_CLOSE_CNT 4

`endif

// ==== bpsi_pkg.sv ====
`default_nettype none

`include "bpsi_macros.svh"

package bpsi_pkg;

    // pid sequencer, one state per pipeline step
    typedef enum logic [2:0] {
        IDLE     = 3'd0,
        CALC_ERR = 3'd1,
        MULT     = 3'd2,
        SUM      = 3'd3,
        DRIVE    = 3'd4
    } pid_state_e;

    // config register map, address 7 unused
    typedef enum logic [2:0] {
        CFG_KP      = 3'd0,
        CFG_KI      = 3'd1,
        CFG_KD      = 3'd2,
        CFG_AIM     = 3'd3,
        CFG_BIAS    = 3'd4,
        CFG_ERR_THR = 3'd5,
        CFG_CTRL    = 3'd6
    } cfg_addr_e;

    // motor read rate, code 3 illegal
    typedef enum logic [1:0] {
        FREQ_100HZ = 2'd0,
        FREQ_200HZ = 2'd1,
        FREQ_300HZ = 2'd2
    } motor_freq_e;

    typedef logic signed [`BPSI_POS_W-1:0] position_t;
    typedef logic [`BPSI_VOL_W-1:0] motor_vol_t;
    typedef logic [`BPSI_COEF_W-1:0] coef_t;

endpackage

`default_nettype wire

// ==== bpsi_cfg_regs.sv ====
`default_nettype none

`include "bpsi_macros.svh"

module bpsi_cfg_regs (
    input  wire                     clk_sys_i,
    input  wire                     rst_i,

    // single cycle write strobe, no handshake
    input  wire                     cfg_we_i,
    input  wire bpsi_pkg::cfg_addr_e cfg_addr_i,
    input  wire [31:0]              cfg_wdata_i,

    // pid coefficients
    output bpsi_pkg::coef_t         kp_o,
    output bpsi_pkg::coef_t         ki_o,
    output bpsi_pkg::coef_t         kd_o,

    // loop target and limits
    output bpsi_pkg::position_t     aim_o,
    output bpsi_pkg::motor_vol_t    bias_o,
    output bpsi_pkg::position_t     err_thr_o,

    // ctrl register fields
    output logic                    acq_en_o,
    output logic                    bias_vol_en_o,
    output bpsi_pkg::motor_freq_e   freq_sel_o
);

////////////////////////////////////////////////////////////
// register file
////////////////////////////////////////////////////////////

// write data truncated to field width
// new value visible the cycle after the strobe
always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
        kp_o          <= '0;
        ki_o          <= '0;
        kd_o          <= '0;
        aim_o         <= '0;
        bias_o        <= '0;
        err_thr_o     <= '0;
        acq_en_o      <= 1'b0;
        bias_vol_en_o <= 1'b0;
        freq_sel_o    <= bpsi_pkg::FREQ_100HZ;
    end else if (cfg_we_i) begin
        case (cfg_addr_i)
            bpsi_pkg::CFG_KP:      kp_o      <= cfg_wdata_i[`BPSI_COEF_W-1:0];
            bpsi_pkg::CFG_KI:      ki_o      <= cfg_wdata_i[`BPSI_COEF_W-1:0];
            bpsi_pkg::CFG_KD:      kd_o      <= cfg_wdata_i[`BPSI_COEF_W-1:0];
            bpsi_pkg::CFG_AIM:     aim_o     <= cfg_wdata_i[`BPSI_POS_W-1:0];
            bpsi_pkg::CFG_BIAS:    bias_o    <= cfg_wdata_i[`BPSI_VOL_W-1:0];
            bpsi_pkg::CFG_ERR_THR: err_thr_o <= cfg_wdata_i[`BPSI_POS_W-1:0];
            bpsi_pkg::CFG_CTRL: begin
                // bit0 acq_en, bit1 bias_vol_en, bits 3:2 freq_sel
                acq_en_o      <= cfg_wdata_i[0];
                bias_vol_en_o <= cfg_wdata_i[1];
                freq_sel_o    <= bpsi_pkg::motor_freq_e'(cfg_wdata_i[3:2]);
            end
            default: begin
                // unmapped address, write dropped
            end
        endcase
    end
end

////////////////////////////////////////////////////////////
// checks
////////////////////////////////////////////////////////////

// motor trigger has no period for code 3
a_freq_legal: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    (cfg_we_i && cfg_addr_i == bpsi_pkg::CFG_CTRL) |=> (freq_sel_o != 2'd3));

endmodule

`default_nettype wire

// ==== bpsi_motor_if.sv ====
`default_nettype none

`include "bpsi_macros.svh"

module bpsi_motor_if (
    input  wire                        clk_sys_i,
    input  wire                        rst_i,

    input  wire                        bias_vol_en_i,
    input  wire bpsi_pkg::motor_freq_e freq_sel_i,

    // feedback word from motor
    input  wire                        motor_ufeed_en_i,
    input  wire bpsi_pkg::motor_vol_t  motor_ufeed_i,

    output logic                       motor_rd_en_o,
    output bpsi_pkg::motor_vol_t       motor_ufeed_latch_o
);

// sized for the longest period
localparam int CNT_W = $clog2(`BPSI_TRIG_100HZ + 1);

logic [CNT_W-1:0]      period_c;
logic [CNT_W-1:0]      cnt_q;
bpsi_pkg::motor_freq_e freq_q;

////////////////////////////////////////////////////////////
// read trigger
////////////////////////////////////////////////////////////

// period lookup, illegal code falls back to slowest rate
always_comb begin
    case (freq_sel_i)
        bpsi_pkg::FREQ_200HZ: period_c = CNT_W'(`BPSI_TRIG_200HZ);
        bpsi_pkg::FREQ_300HZ: period_c = CNT_W'(`BPSI_TRIG_300HZ);
        default:              period_c = CNT_W'(`BPSI_TRIG_100HZ);
    endcase
end

// first pulse one full period after enable
// restart on disable or on rate change
always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
        cnt_q         <= '0;
        freq_q        <= bpsi_pkg::FREQ_100HZ;
        motor_rd_en_o <= 1'b0;
    end else begin
        freq_q        <= freq_sel_i;
        motor_rd_en_o <= 1'b0;
        if (!bias_vol_en_i || (freq_sel_i != freq_q)) begin
            cnt_q <= '0;
        end else if (cnt_q == period_c - 1'b1) begin
            cnt_q         <= '0;
            motor_rd_en_o <= 1'b1;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end
end

////////////////////////////////////////////////////////////
// ufeed latch
////////////////////////////////////////////////////////////

always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
        motor_ufeed_latch_o <= '0;
    end else if (motor_ufeed_en_i) begin
        motor_ufeed_latch_o <= motor_ufeed_i;
    end
end

// trigger is a single cycle strobe
a_rd_pulse: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    motor_rd_en_o |=> !motor_rd_en_o);

endmodule

`default_nettype wire

// ==== bpsi_position_calc.sv ====
`default_nettype none

`include "bpsi_macros.svh"

module bpsi_position_calc (
    input  wire                     clk_sys_i,
    input  wire                     rst_i,

    // raw sensor sample in
    input  wire                     sample_valid_i,
    input  wire [`BPSI_SENS_W-1:0]  sample_a_i,
    input  wire [`BPSI_SENS_W-1:0]  sample_b_i,
    output logic                    sample_ready_o,

    // position out to pid
    output logic                    pos_valid_o,
    output bpsi_pkg::position_t     pos_data_o,
    input  wire                     pos_ready_i
);

logic                sample_fire;
bpsi_pkg::position_t diff_c;

////////////////////////////////////////////////////////////
// handshake
////////////////////////////////////////////////////////////

// slot free, or draining this cycle
assign sample_ready_o = !pos_valid_o || pos_ready_i;
assign sample_fire    = sample_valid_i && sample_ready_o;

// a - b, both unsigned, one extra bit holds the sign
assign diff_c = $signed({1'b0, sample_a_i}) - $signed({1'b0, sample_b_i});

////////////////////////////////////////////////////////////
// one entry stage
////////////////////////////////////////////////////////////

always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
        pos_valid_o <= 1'b0;
    end else if (sample_fire) begin
        pos_valid_o <= 1'b1;
    end else if (pos_ready_i) begin
        pos_valid_o <= 1'b0;
    end
end

// payload only, qualified by pos_valid_o
always_ff @(posedge clk_sys_i) begin
    if (sample_fire) begin
        pos_data_o <= diff_c;
    end
end

// held stable while pid is busy
a_pos_hold: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    (pos_valid_o && !pos_ready_i) |=> (pos_valid_o && $stable(pos_data_o)));

endmodule

`default_nettype wire

// ==== bpsi_pid_ctrl.sv ====
`default_nettype none

`include "bpsi_macros.svh"

module bpsi_pid_ctrl (
    input  wire                       clk_sys_i,
    input  wire                       rst_i,

    // position from sensor stage
    input  wire                       pos_valid_i,
    input  wire bpsi_pkg::position_t  pos_data_i,
    output logic                      pos_ready_o,

    // configuration
    input  wire                       acq_en_i,
    input  wire bpsi_pkg::coef_t      kp_i,
    input  wire bpsi_pkg::coef_t      ki_i,
    input  wire bpsi_pkg::coef_t      kd_i,
    input  wire bpsi_pkg::position_t  aim_i,
    input  wire bpsi_pkg::position_t  err_thr_i,
    input  wire bpsi_pkg::motor_vol_t bias_i,

    // drive word to motor, no back-pressure
    output logic                      motor_data_in_en_o,
    output bpsi_pkg::motor_vol_t      motor_data_in_o,
    output logic                      fbc_close_state_o
);

// err one bit wider than position, deriv one wider again
localparam int ERR_W   = `BPSI_POS_W + 1;
localparam int DER_W   = ERR_W + 1;
localparam int PROD_W  = 64;
// integral sized so ki product fits 64 bits
localparam int INTEG_W = PROD_W - `BPSI_COEF_W - 1;
localparam int CNT_W   = $clog2(`BPSI_CLOSE_CNT + 1);

bpsi_pkg::pid_state_e     state_q;
bpsi_pkg::position_t      pos_q;
logic                     pos_fire;

logic signed [ERR_W-1:0]   err_c;
logic signed [ERR_W-1:0]   err_abs_c;
logic signed [ERR_W-1:0]   err_q;
logic signed [ERR_W-1:0]   prev_err_q;
logic signed [DER_W-1:0]   deriv_q;
logic signed [INTEG_W-1:0] integ_q;
logic                      in_thr_q;

logic signed [PROD_W-1:0] p_kp_q;
logic signed [PROD_W-1:0] p_ki_q;
logic signed [PROD_W-1:0] p_kd_q;
logic signed [PROD_W-1:0] sum_c;
logic signed [PROD_W-1:0] drive_c;
bpsi_pkg::motor_vol_t     drive_sat_c;

logic [CNT_W-1:0] close_cnt_q;

////////////////////////////////////////////////////////////
// datapath
////////////////////////////////////////////////////////////

// accept only between samples
assign pos_ready_o = (state_q == bpsi_pkg::IDLE);
assign pos_fire    = pos_valid_i && pos_ready_o;

// aim - position, sign extended by context
assign err_c     = aim_i - pos_q;
assign err_abs_c = err_c[ERR_W-1] ? -err_c : err_c;

// sum of products back to integer scale, plus bias
always_comb begin
    sum_c   = p_kp_q + p_ki_q + p_kd_q;
    drive_c = (sum_c >>> `BPSI_COEF_FRAC)
            + $signed({{(PROD_W - `BPSI_VOL_W){1'b0}}, bias_i});
    // clamp to 0 .. full scale
    if (drive_c[PROD_W-1]) begin
        drive_sat_c = '0;
    end else if (|drive_c[PROD_W-2:`BPSI_VOL_W]) begin
        drive_sat_c = '1;
    end else begin
        drive_sat_c = drive_c[`BPSI_VOL_W-1:0];
    end
end

// pipeline payload, no reset
always_ff @(posedge clk_sys_i) begin
    if (pos_fire) begin
        pos_q <= pos_data_i;
    end
    if (state_q == bpsi_pkg::CALC_ERR) begin
        err_q    <= err_c;
        deriv_q  <= err_c - prev_err_q;
        in_thr_q <= (err_abs_c <= err_thr_i);
    end
    if (state_q == bpsi_pkg::MULT) begin
        // coefficients unsigned, zero extend before signed multiply
        p_kp_q <= $signed({1'b0, kp_i}) * err_q;
        p_ki_q <= $signed({1'b0, ki_i}) * integ_q;
        p_kd_q <= $signed({1'b0, kd_i}) * deriv_q;
    end
end

////////////////////////////////////////////////////////////
// sequencer
////////////////////////////////////////////////////////////

always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
        state_q            <= bpsi_pkg::IDLE;
        motor_data_in_en_o <= 1'b0;
        motor_data_in_o    <= '0;
        integ_q            <= '0;
        prev_err_q         <= '0;
        close_cnt_q        <= '0;
    end else begin
        motor_data_in_en_o <= 1'b0;
        case (state_q)
            bpsi_pkg::IDLE: begin
                // acquisition off, loop history dropped
                if (!acq_en_i) begin
                    integ_q     <= '0;
                    prev_err_q  <= '0;
                    close_cnt_q <= '0;
                end
                // samples taken with acq off are discarded
                if (pos_fire && acq_en_i) begin
                    state_q <= bpsi_pkg::CALC_ERR;
                end
            end
            bpsi_pkg::CALC_ERR: begin
                integ_q    <= integ_q + err_c;
                prev_err_q <= err_c;
                state_q    <= bpsi_pkg::MULT;
            end
            bpsi_pkg::MULT: begin
                state_q <= bpsi_pkg::SUM;
            end
            bpsi_pkg::SUM: begin
                motor_data_in_o    <= drive_sat_c;
                motor_data_in_en_o <= 1'b1;
                // close count saturates, any miss restarts it
                if (!in_thr_q) begin
                    close_cnt_q <= '0;
                end else if (close_cnt_q != CNT_W'(`BPSI_CLOSE_CNT)) begin
                    close_cnt_q <= close_cnt_q + 1'b1;
                end
                state_q <= bpsi_pkg::DRIVE;
            end
            bpsi_pkg::DRIVE: begin
                state_q <= bpsi_pkg::IDLE;
            end
            default: begin
                state_q <= bpsi_pkg::IDLE;
            end
        endcase
    end
end

// changes together with the drive pulse
assign fbc_close_state_o = (close_cnt_q == CNT_W'(`BPSI_CLOSE_CNT));

////////////////////////////////////////////////////////////
// checks
////////////////////////////////////////////////////////////

// busy four cycles, one drive pulse on the last, then ready again
a_pid_latency: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    (pos_fire && acq_en_i) |=> !pos_ready_o [*3]
        ##1 (!pos_ready_o && motor_data_in_en_o) ##1 pos_ready_o);

// drive strobe only out of DRIVE, one cycle wide
a_drive_state: assert property (@(posedge clk_sys_i) disable iff (rst_i)
    motor_data_in_en_o |-> (state_q == bpsi_pkg::DRIVE) ##1 !motor_data_in_en_o);

endmodule

`default_nettype wire

// ==== bpsi_top.sv ====
`default_nettype none

`include "bpsi_macros.svh"

module bpsi_top (
    input  wire                      clk_sys_i,
    input  wire                      rst_i,

    // configuration port
    input  wire                      cfg_we_i,
    input  wire bpsi_pkg::cfg_addr_e cfg_addr_i,
    input  wire [31:0]               cfg_wdata_i,

    // FBCi sensor samples
    input  wire                      sample_valid_i,
    input  wire [`BPSI_SENS_W-1:0]   sample_a_i,
    input  wire [`BPSI_SENS_W-1:0]   sample_b_i,
    output logic                     sample_ready_o,

    // motor side
    input  wire                      motor_ufeed_en_i,
    input  wire [`BPSI_VOL_W-1:0]    motor_ufeed_i,
    output logic                     motor_rd_en_o,
    output logic [`BPSI_VOL_W-1:0]   motor_ufeed_latch_o,
    output logic                     motor_data_in_en_o,
    output logic [`BPSI_VOL_W-1:0]   motor_data_in_o,
    output logic                     fbc_close_state_o
);

////////////////////////////////////////////////////////////
// internal nets
////////////////////////////////////////////////////////////

// config fields
bpsi_pkg::coef_t       kp;
bpsi_pkg::coef_t       ki;
bpsi_pkg::coef_t       kd;
bpsi_pkg::position_t   aim;
bpsi_pkg::motor_vol_t  bias;
bpsi_pkg::position_t   err_thr;
logic                  acq_en;
logic                  bias_vol_en;
bpsi_pkg::motor_freq_e freq_sel;

// position link, calc to pid
logic                  pos_valid;
bpsi_pkg::position_t   pos_data;
logic                  pos_ready;

////////////////////////////////////////////////////////////
// blocks
////////////////////////////////////////////////////////////

bpsi_cfg_regs u_cfg_regs (
    .clk_sys_i     (clk_sys_i),
    .rst_i         (rst_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .kp_o          (kp),
    .ki_o          (ki),
    .kd_o          (kd),
    .aim_o         (aim),
    .bias_o        (bias),
    .err_thr_o     (err_thr),
    .acq_en_o      (acq_en),
    .bias_vol_en_o (bias_vol_en),
    .freq_sel_o    (freq_sel)
);

// periodic Ufeed read, independent of the sample path
bpsi_motor_if u_motor_if (
    .clk_sys_i           (clk_sys_i),
    .rst_i               (rst_i),
    .bias_vol_en_i       (bias_vol_en),
    .freq_sel_i          (freq_sel),
    .motor_ufeed_en_i    (motor_ufeed_en_i),
    .motor_ufeed_i       (motor_ufeed_i),
    .motor_rd_en_o       (motor_rd_en_o),
    .motor_ufeed_latch_o (motor_ufeed_latch_o)
);

bpsi_position_calc u_position_calc (
    .clk_sys_i      (clk_sys_i),
    .rst_i          (rst_i),
    .sample_valid_i (sample_valid_i),
    .sample_a_i     (sample_a_i),
    .sample_b_i     (sample_b_i),
    .sample_ready_o (sample_ready_o),
    .pos_valid_o    (pos_valid),
    .pos_data_o     (pos_data),
    .pos_ready_i    (pos_ready)
);

// sample handshake to drive pulse is five cycles when pid idle
bpsi_pid_ctrl u_pid_ctrl (
    .clk_sys_i          (clk_sys_i),
    .rst_i              (rst_i),
    .pos_valid_i        (pos_valid),
    .pos_data_i         (pos_data),
    .pos_ready_o        (pos_ready),
    .acq_en_i           (acq_en),
    .kp_i               (kp),
    .ki_i               (ki),
    .kd_i               (kd),
    .aim_i              (aim),
    .err_thr_i          (err_thr),
    .bias_i             (bias),
    .motor_data_in_en_o (motor_data_in_en_o),
    .motor_data_in_o    (motor_data_in_o),
    .fbc_close_state_o  (fbc_close_state_o)
);

endmodule

`default_nettype wire

// ==== tb_bpsi_top.sv ====
`default_nettype none

`include "bpsi_macros.svh"

module tb_bpsi_top;

// random samples plus burst, close and acq-off samples
localparam int NUM_RANDOM     = 200;
localparam int NUM_BURST      = 8;
localparam int TOTAL_SAMPLES  = NUM_RANDOM + NUM_BURST + 5 + 3;
localparam int TIMEOUT_CYCLES = 20 * (TOTAL_SAMPLES * 8 + 4 * 300);
// longest wait is two samples through the pid
localparam int DRAIN_CYCLES   = 20;

logic                     clk_sys;
logic                     rst;
logic                     cfg_we;
bpsi_pkg::cfg_addr_e      cfg_addr;
logic [31:0]              cfg_wdata;
logic                     sample_valid;
logic [`BPSI_SENS_W-1:0]  sample_a;
logic [`BPSI_SENS_W-1:0]  sample_b;
logic                     sample_ready;
logic                     motor_ufeed_en;
logic [`BPSI_VOL_W-1:0]   motor_ufeed;
logic                     motor_rd_en;
logic [`BPSI_VOL_W-1:0]   motor_ufeed_latch;
logic                     motor_data_in_en;
logic [`BPSI_VOL_W-1:0]   motor_data_in;
logic                     fbc_close_state;

// config mirror for the model
longint cfg_kp;
longint cfg_ki;
longint cfg_kd;
longint cfg_aim;
longint cfg_bias;
longint cfg_thr;
logic   tb_acq_en;

// model loop history
longint m_integ;
longint m_prev_err;
int     m_close_cnt;
logic   m_close;

// accepted positions waiting for their drive pulse
longint pend_q[$];
int     acc_cycle_q[$];
int     latency_log[$];
int     accept_count;
int     pulse_count;
int     cycle_cnt;

bpsi_top uut (
    .clk_sys_i           (clk_sys),
    .rst_i               (rst),
    .cfg_we_i            (cfg_we),
    .cfg_addr_i          (cfg_addr),
    .cfg_wdata_i         (cfg_wdata),
    .sample_valid_i      (sample_valid),
    .sample_a_i          (sample_a),
    .sample_b_i          (sample_b),
    .sample_ready_o      (sample_ready),
    .motor_ufeed_en_i    (motor_ufeed_en),
    .motor_ufeed_i       (motor_ufeed),
    .motor_rd_en_o       (motor_rd_en),
    .motor_ufeed_latch_o (motor_ufeed_latch),
    .motor_data_in_en_o  (motor_data_in_en),
    .motor_data_in_o     (motor_data_in),
    .fbc_close_state_o   (fbc_close_state)
);

initial begin
    clk_sys = 1'b0;
    forever #10 clk_sys = ~clk_sys;
end

////////////////////////////////////////////////////////////
// error exit and reference model
////////////////////////////////////////////////////////////

task automatic fail_run(input bit is_value, input string msg);
    if (is_value) begin
        $display("FAIL %0t: %s", $time, msg);
    end else begin
        $display("error at time %0t: %s", $time, msg);
    end
    $display("sim failed");
    $fatal(1, "run stopped on first error");
endtask

// err = aim - pos, pid sum scaled back by the fraction bits, clamp 0..65535
function automatic logic [15:0] pid_model(input longint pos);
    longint err;
    longint deriv;
    longint sum;
    longint out;
    logic [15:0] word;
    err        = cfg_aim - pos;
    m_integ    = m_integ + err;
    deriv      = err - m_prev_err;
    m_prev_err = err;
    sum = cfg_kp * err + cfg_ki * m_integ + cfg_kd * deriv;
    out = cfg_bias + (sum >>> `BPSI_COEF_FRAC);
    // close count saturates and any miss restarts it
    if ((err < 0 ? -err : err) <= cfg_thr) begin
        if (m_close_cnt < `BPSI_CLOSE_CNT) begin
            m_close_cnt = m_close_cnt + 1;
        end
    end else begin
        m_close_cnt = 0;
    end
    m_close = (m_close_cnt == `BPSI_CLOSE_CNT);
    if (out < 0) begin
        word = 16'h0000;
    end else if (out > 65535) begin
        word = 16'hffff;
    end else begin
        word = out[15:0];
    end
    return word;
endfunction

////////////////////////////////////////////////////////////
// monitors
////////////////////////////////////////////////////////////

always @(posedge clk_sys) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
        fail_run(1'b0, "timeout, no progress within the cycle limit");
    end
end

// record every sample the pid will process
// samples taken with acq off are dropped by the dut
always @(posedge clk_sys) begin
    if (!rst && sample_valid && sample_ready && tb_acq_en) begin
        pend_q.push_back(longint'(sample_a) - longint'(sample_b));
        acc_cycle_q.push_back(cycle_cnt);
        accept_count = accept_count + 1;
    end
end

// compare each drive pulse against the oldest sample
always @(posedge clk_sys) begin
    longint      pos;
    logic [15:0] exp_word;
    if (!rst && motor_data_in_en) begin
        assert (pend_q.size() != 0)
            else fail_run(1'b0, "drive pulse with no accepted sample pending");
        if (pend_q.size() != 0) begin
            pos = pend_q.pop_front();
            latency_log.push_back(cycle_cnt - acc_cycle_q.pop_front());
            exp_word    = pid_model(pos);
            pulse_count = pulse_count + 1;
            assert (motor_data_in == exp_word)
                else fail_run(1'b1, $sformatf("drive word %0d, expected %0d for pos %0d",
                                              motor_data_in, exp_word, pos));
            assert (fbc_close_state == m_close)
                else fail_run(1'b1, $sformatf("close state %0b, expected %0b",
                                              fbc_close_state, m_close));
        end
    end
end

////////////////////////////////////////////////////////////
// stimulus tasks start and end 2 units past an edge
////////////////////////////////////////////////////////////

task automatic write_cfg(input bpsi_pkg::cfg_addr_e addr, input logic [31:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(posedge clk_sys);
    #2;
    cfg_we = 1'b0;
endtask

task automatic write_ctrl(input logic acq, input logic bven, input bpsi_pkg::motor_freq_e sel);
    write_cfg(bpsi_pkg::CFG_CTRL, {28'd0, sel, bven, acq});
    tb_acq_en = acq;
    // dut drops loop history while acq is off
    if (!acq) begin
        m_integ     = 0;
        m_prev_err  = 0;
        m_close_cnt = 0;
    end
endtask

// idle gap first, then hold valid until the handshake
task automatic send_sample(input logic [23:0] a, input logic [23:0] b, input int gap);
    if (gap > 0) begin
        sample_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk_sys);
            #2;
        end
    end
    sample_valid = 1'b1;
    sample_a     = a;
    sample_b     = b;
    @(posedge clk_sys);
    while (!sample_ready) @(posedge clk_sys);
    #2;
endtask

task automatic wait_drain();
    int waited;
    waited = 0;
    // a missing drive pulse ends the wait and shows in the counts
    while (pend_q.size() != 0 && waited < DRAIN_CYCLES) begin
        @(posedge clk_sys);
        #2;
        waited = waited + 1;
    end
endtask

task automatic wait_rd_pulse(output int t);
    @(posedge clk_sys);
    while (!motor_rd_en) @(posedge clk_sys);
    t = cycle_cnt;
    #2;
endtask

task automatic check_trigger_rate(input bpsi_pkg::motor_freq_e sel, input int period);
    int t0;
    int t1;
    write_ctrl(tb_acq_en, 1'b1, sel);
    wait_rd_pulse(t0);
    repeat (2) begin
        wait_rd_pulse(t1);
        assert (t1 - t0 == period)
            else fail_run(1'b1, $sformatf("trigger gap %0d, expected %0d", t1 - t0, period));
        t0 = t1;
    end
endtask

////////////////////////////////////////////////////////////
// test sequence
////////////////////////////////////////////////////////////

initial begin
    int          first_idx;
    int          pulses0;
    logic [23:0] b;
    logic [15:0] ufeed_val;
    cycle_cnt      = 0;
    accept_count   = 0;
    pulse_count    = 0;
    tb_acq_en      = 1'b0;
    m_integ        = 0;
    m_prev_err     = 0;
    m_close_cnt    = 0;
    m_close        = 1'b0;
    rst            = 1'b1;
    cfg_we         = 1'b0;
    cfg_addr       = bpsi_pkg::CFG_KP;
    cfg_wdata      = '0;
    sample_valid   = 1'b0;
    sample_a       = '0;
    sample_b       = '0;
    motor_ufeed_en = 1'b0;
    motor_ufeed    = '0;
    void'($urandom(32'h7dbdb220));
    repeat (5) @(posedge clk_sys);
    #2;
    rst = 1'b0;

    // reset values
    assert (!motor_rd_en && !motor_data_in_en && !fbc_close_state)
        else fail_run(1'b0, "strobe or close state high after reset");
    assert (motor_data_in == 16'd0 && motor_ufeed_latch == 16'd0)
        else fail_run(1'b1, "drive word or ufeed latch not zero after reset");
    assert (sample_ready) else fail_run(1'b0, "sample_ready low after reset");

    // loop settings kept small so the drive is not always clamped
    cfg_kp   = $urandom_range(0, 1 << 18);
    cfg_ki   = $urandom_range(0, 1 << 8);
    cfg_kd   = $urandom_range(0, 1 << 18);
    cfg_aim  = $urandom_range(0, 1 << 16);
    cfg_bias = $urandom_range(0, 65535);
    cfg_thr  = $urandom_range(0, 1 << 10);
    write_cfg(bpsi_pkg::CFG_KP, 32'(cfg_kp));
    write_cfg(bpsi_pkg::CFG_KI, 32'(cfg_ki));
    write_cfg(bpsi_pkg::CFG_KD, 32'(cfg_kd));
    write_cfg(bpsi_pkg::CFG_AIM, 32'(cfg_aim));
    write_cfg(bpsi_pkg::CFG_BIAS, 32'(cfg_bias));
    write_cfg(bpsi_pkg::CFG_ERR_THR, 32'(cfg_thr));
    write_ctrl(1'b1, 1'b0, bpsi_pkg::FREQ_100HZ);

    repeat (NUM_RANDOM) begin
        send_sample(24'($urandom_range(0, 1 << 17)), 24'($urandom_range(0, 1 << 17)),
                    $urandom_range(0, 3));
    end
    sample_valid = 1'b0;
    wait_drain();
    assert (pulse_count == accept_count)
        else fail_run(1'b1, $sformatf("%0d pulses for %0d samples", pulse_count, accept_count));

    // back to back burst starting with the pid idle
    first_idx = pulse_count;
    repeat (NUM_BURST) begin
        send_sample(24'($urandom_range(0, 1 << 17)), 24'($urandom_range(0, 1 << 17)), 0);
    end
    sample_valid = 1'b0;
    wait_drain();
    assert (pulse_count - first_idx == NUM_BURST)
        else fail_run(1'b1, $sformatf("burst gave %0d drive pulses", pulse_count - first_idx));
    assert (latency_log[first_idx] == 5)
        else fail_run(1'b1, $sformatf("first burst latency %0d", latency_log[first_idx]));

    // motor read trigger rates
    check_trigger_rate(bpsi_pkg::FREQ_100HZ, `BPSI_TRIG_100HZ);
    check_trigger_rate(bpsi_pkg::FREQ_200HZ, `BPSI_TRIG_200HZ);
    check_trigger_rate(bpsi_pkg::FREQ_300HZ, `BPSI_TRIG_300HZ);
    write_ctrl(tb_acq_en, 1'b0, bpsi_pkg::FREQ_100HZ);
    // one pulse may still be in flight from the write cycle
    @(posedge clk_sys);
    #2;
    repeat (`BPSI_TRIG_100HZ + 50) begin
        @(posedge clk_sys);
        assert (!motor_rd_en) else fail_run(1'b0, "read trigger while disabled");
    end
    #2;

    // ufeed latch
    ufeed_val      = 16'($urandom);
    motor_ufeed_en = 1'b1;
    motor_ufeed    = ufeed_val;
    @(posedge clk_sys);
    #2;
    motor_ufeed_en = 1'b0;
    assert (motor_ufeed_latch == ufeed_val)
        else fail_run(1'b1, $sformatf("ufeed latch %h, expected %h", motor_ufeed_latch, ufeed_val));

    // clear loop history before closed loop detect
    write_ctrl(1'b0, 1'b0, bpsi_pkg::FREQ_100HZ);
    write_ctrl(1'b1, 1'b0, bpsi_pkg::FREQ_100HZ);
    cfg_thr = 64;
    write_cfg(bpsi_pkg::CFG_ERR_THR, 32'(cfg_thr));
    repeat (`BPSI_CLOSE_CNT) begin
        b = 24'($urandom_range(0, 1 << 16));
        send_sample(24'(cfg_aim) + b, b, 0);
    end
    sample_valid = 1'b0;
    wait_drain();
    assert (fbc_close_state) else fail_run(1'b1, "loop not closed after samples at aim");
    b = 24'($urandom_range(0, 1 << 16));
    send_sample(24'(cfg_aim + cfg_thr + 1) + b, b, 0);
    sample_valid = 1'b0;
    wait_drain();
    assert (!fbc_close_state) else fail_run(1'b1, "loop still closed after a miss");

    // with acq off samples are taken but never driven
    write_ctrl(1'b0, 1'b0, bpsi_pkg::FREQ_100HZ);
    pulses0 = pulse_count;
    repeat (3) begin
        send_sample(24'($urandom), 24'($urandom), 1);
    end
    sample_valid = 1'b0;
    repeat (20) @(posedge clk_sys);
    #2;
    assert (pulse_count == pulses0) else fail_run(1'b0, "drive pulse with acq_en clear");

    $display("sim passed");
    $finish;
end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
bpsi_pkg.sv
bpsi_cfg_regs.sv
bpsi_motor_if.sv
bpsi_position_calc.sv
bpsi_pid_ctrl.sv
bpsi_top.sv
tb_bpsi_top.sv

// ==== Makefile ====
TOOL    = verilator
FLAGS   = --binary --timing --assert -Wno-fatal
TOP     = tb_bpsi_top
FLIST   = verilog.f
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
